// ==== snakeGame.f ====
rtl/snakePkg.sv
rtl/snakeBody.sv
rtl/collisionCheck.sv
rtl/drawController.sv
rtl/snakeGame.sv
testbench/snakeGameTb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = snakeGameTb
FILELIST  = snakeGame.f
OBJDIR    = obj_dir
SIM       = $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# pass only when the simulation prints the pass line
run: compile
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(OBJDIR)

// ==== testbench/snakeGameTb.sv ====
// snakeGameTb: stimulus table, snake reference model, pixel compare, watchdog and summary
`timescale 1ns/1ns

module snakeGameTb;

    // one stimulus row
    typedef struct packed {
        logic [3:0]        keys;
        logic              go;
        snakePkg::colour_t colour;
        logic [7:0]        frames;
        logic              over;
    } row_t;

    localparam int numRows = 9;

    // keys are right, down, up, left from msb
    row_t rows [numRows] = '{
        '{4'b0000, 1'b0, 3'b010, 8'd3, 1'b0},  // go low, screen stays quiet
        '{4'b0010, 1'b1, 3'b010, 8'd3, 1'b0},  // up
        '{4'b0000, 1'b1, 3'b001, 8'd2, 1'b0},  // no key, heading held
        '{4'b1000, 1'b1, 3'b011, 8'd2, 1'b1},  // right turn runs into segment 1
        '{4'b0001, 1'b1, 3'b110, 8'd2, 1'b1},  // left after reset
        '{4'b1001, 1'b1, 3'b010, 8'd2, 1'b1},  // right beats left
        '{4'b0011, 1'b1, 3'b111, 8'd2, 1'b0},  // up beats left
        '{4'b0110, 1'b1, 3'b001, 8'd1, 1'b1},  // down beats up, reversal
        '{4'b0000, 1'b1, 3'b101, 8'd2, 1'b0}   // start position again
    };

    logic                Clock = 1'b0;
    logic                reset;
    logic                go;
    snakePkg::dirKeys_t  keys;
    snakePkg::colour_t   snakeColour;
    snakePkg::pixelOut_t pixel;
    logic                gameOver;

    // reference history, entry 0 is the head
    snakePkg::xCoord_t hx [snakePkg::historyDepth];
    snakePkg::yCoord_t hy [snakePkg::historyDepth];
    // 0 up, 1 down, 2 left, 3 right
    int                modelDir;
    logic              pendingStep;
    int                checks = 0;
    int                errors = 0;

    snakeGame snakeGame_inst
    (
        .Clock       (Clock),
        .reset       (reset),
        .go          (go),
        .keys        (keys),
        .snakeColour (snakeColour),
        .pixel       (pixel),
        .gameOver    (gameOver)
    );

    // 4 ns period
    always #2 Clock = ~Clock;

    task automatic resetModel();
        for (int i = 0; i < snakePkg::historyDepth; i++)
        begin
            hx[i] = snakePkg::startX;
            hy[i] = snakePkg::startY + snakePkg::yCoord_t'(i);
        end
        modelDir    = 0;
        pendingStep = 1'b0;
    endtask

    // shift toward the tail, new head one pixel along the heading
    task automatic stepModel();
        for (int i = snakePkg::historyDepth - 1; i > 0; i--)
        begin
            hx[i] = hx[i-1];
            hy[i] = hy[i-1];
        end
        case (modelDir)
            0:       hy[0] = hy[0] - 7'd1;
            1:       hy[0] = hy[0] + 7'd1;
            2:       hx[0] = hx[0] - 8'd1;
            default: hx[0] = hx[0] + 8'd1;
        endcase
    endtask

    // head square against segments 1 to 5
    function automatic logic predictHit();
        int   dx;
        int   dy;
        int   idx;
        logic h;
        h = 1'b0;
        for (int k = 1; k < snakePkg::snakeLength; k++)
        begin
            idx = k * snakePkg::cellSize;
            dx  = int'(hx[0]) - int'(hx[idx]);
            dy  = int'(hy[0]) - int'(hy[idx]);
            if (dx < 0) dx = -dx;
            if (dy < 0) dy = -dy;
            if (dx < snakePkg::cellSize && dy < snakePkg::cellSize) h = 1'b1;
        end
        return h;
    endfunction

    // drive a row's levels, model heading follows the key priority
    task automatic applyInputs(input int r);
        keys        = snakePkg::dirKeys_t'(rows[r].keys);
        go          = rows[r].go;
        snakeColour = rows[r].colour;
        if (rows[r].keys[3]) modelDir = 3;
        else if (rows[r].keys[2]) modelDir = 1;
        else if (rows[r].keys[1]) modelDir = 0;
        else if (rows[r].keys[0]) modelDir = 2;
    endtask

    // monitor one frame: apple, body tail first, then erase
    task automatic comparePixels(input snakePkg::colour_t colour);
        int                sq;
        int                n;
        int                m;
        int                p;
        int                idx;
        snakePkg::xCoord_t ex;
        snakePkg::yCoord_t ey;
        snakePkg::colour_t ec;
        sq = snakePkg::cellSize * snakePkg::cellSize;
        n  = 0;
        while (n < sq * (1 + 2 * snakePkg::snakeLength))
        begin
            @(negedge Clock);
            if (pixel.plot)
            begin
                if (n < sq)
                begin
                    ex = snakePkg::appleX + snakePkg::xCoord_t'(n % snakePkg::cellSize);
                    ey = snakePkg::appleY + snakePkg::yCoord_t'(n / snakePkg::cellSize);
                    ec = snakePkg::appleColour;
                end
                else
                begin
                    m   = (n - sq) % (sq * snakePkg::snakeLength);
                    idx = (snakePkg::snakeLength - 1 - m / sq) * snakePkg::cellSize;
                    p   = m % sq;
                    ex  = hx[idx] + snakePkg::xCoord_t'(p % snakePkg::cellSize);
                    ey  = hy[idx] + snakePkg::yCoord_t'(p / snakePkg::cellSize);
                    ec  = (n < sq * (1 + snakePkg::snakeLength)) ? colour : snakePkg::eraseColour;
                end
                checks++;
                assert (pixel.x == ex && pixel.y == ey && pixel.colour == ec)
                else
                begin
                    $display("mismatch at %0t ns: pixel %0d is (%0d,%0d) %0d, want (%0d,%0d) %0d",
                             $time, n, pixel.x, pixel.y, pixel.colour, ex, ey, ec);
                    errors++;
                end
                n++;
            end
        end
    endtask

    // go low: no writes, no game over
    task automatic verifyIdle(input int frames);
        repeat (frames * (1 << snakePkg::frameTickBits))
        begin
            @(negedge Clock);
            checks++;
            assert (!pixel.plot && !gameOver)
            else
            begin
                $display("mismatch at %0t ns: plot %b gameOver %b while idle", $time,
                         pixel.plot, gameOver);
                errors++;
            end
        end
    endtask

    // ended game holds with the plot strobe low
    task automatic watchGameOver();
        repeat (2 * (1 << snakePkg::frameTickBits))
        begin
            @(negedge Clock);
            checks++;
            assert (gameOver && !pixel.plot)
            else
            begin
                $display("mismatch at %0t ns: plot %b gameOver %b after the game ended", $time,
                         pixel.plot, gameOver);
                errors++;
            end
        end
    endtask

    task automatic resetDut();
        @(posedge Clock);
        #1 reset = 1'b1;
        repeat (3) @(posedge Clock);
        #1;
        checks++;
        assert (!gameOver)
        else
        begin
            $display("mismatch at %0t ns: gameOver still high during reset", $time);
            errors++;
        end
        reset = 1'b0;
        resetModel();
    endtask

    initial
    begin
        logic over;
        reset       = 1'b1;
        go          = 1'b0;
        keys        = '0;
        snakeColour = '0;
        resetModel();
        repeat (3) @(posedge Clock);
        #1 reset = 1'b0;
        applyInputs(0);
        for (int r = 0; r < numRows; r++)
        begin
            over = 1'b0;
            if (!rows[r].go)
            begin
                verifyIdle(rows[r].frames);
                @(posedge Clock);
                #1 applyInputs(r + 1);
            end
            else
            begin
                for (int f = 0; f < rows[r].frames && !over; f++)
                begin
                    if (pendingStep) stepModel();
                    comparePixels(rows[r].colour);
                    over = predictHit();
                    // checkHit cycle, new keys land before the step
                    @(posedge Clock);
                    #1;
                    if (!over && f == rows[r].frames - 1 && r + 1 < numRows) applyInputs(r + 1);
                    @(negedge Clock);
                    @(negedge Clock);
                    checks++;
                    assert (gameOver == over)
                    else
                    begin
                        $display("mismatch at %0t ns: gameOver %b, model says %b", $time,
                                 gameOver, over);
                        errors++;
                    end
                    pendingStep = !over;
                end
                // row outcome as the table expects it
                checks++;
                assert (gameOver == rows[r].over)
                else
                begin
                    $display("mismatch at %0t ns: row %0d ends with gameOver %b, table wants %b",
                             $time, r, gameOver, rows[r].over);
                    errors++;
                end
                if (over)
                begin
                    watchGameOver();
                    resetDut();
                    if (r + 1 < numRows) applyInputs(r + 1);
                end
            end
            $display("row %0d done: keys %b go %b frames %0d gameOver %b, %0d errors so far",
                     r, rows[r].keys, rows[r].go, rows[r].frames, over, errors);
        end
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
        begin
            $display("TEST PASSED");
        end
        else
        begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // watchdog, 1500 cycles per frame plus reset
    initial
    begin
        int totalFrames;
        totalFrames = 0;
        for (int i = 0; i < numRows; i++)
        begin
            totalFrames += int'(rows[i].frames);
        end
        #((totalFrames * 1500 + 3) * 4);
        $display("timeout: the simulation hung waiting for the DUT");
        $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== rtl/snakeGame.sv ====
// snakeGame: top level joining snake body, collision check and drawing controller
`timescale 1ns/1ns

module snakeGame
(
    input  logic                Clock,
    input  logic                reset,
    input  logic                go,
    input  snakePkg::dirKeys_t  keys,
    input  snakePkg::colour_t   snakeColour,
    output snakePkg::pixelOut_t pixel,
    output logic                gameOver
);

    // segment origins, head first
    snakePkg::segments_t segments;
    logic                hit;
    logic                step;

    snakeBody snakeBody_inst
    (
        .Clock    (Clock),
        .reset    (reset),
        .keys     (keys),
        .step     (step),
        .segments (segments)
    );

    collisionCheck collisionCheck_inst
    (
        .segments (segments),
        .hit      (hit)
    );

    drawController drawController_inst
    (
        .Clock       (Clock),
        .reset       (reset),
        .go          (go),
        .snakeColour (snakeColour),
        .segments    (segments),
        .hit         (hit),
        .step        (step),
        .pixel       (pixel),
        .gameOver    (gameOver)
    );

endmodule

// ==== rtl/drawController.sv ====
// drawController: frame tick, drawing FSM, pixel counters and plot address generation
`timescale 1ns/1ns

module drawController
(
    input  logic                 Clock,
    input  logic                 reset,
    input  logic                 go,
    input  snakePkg::colour_t    snakeColour,
    input  snakePkg::segments_t  segments,
    input  logic                 hit,
    output logic                 step,
    output snakePkg::pixelOut_t  pixel,
    output logic                 gameOver
);

    // free-running animation counter
    logic [snakePkg::frameTickBits-1:0] frameCount;
    logic                               tick;

    snakePkg::drawState_t state;
    snakePkg::drawState_t nextState;

    // pixel offsets inside one square
    logic [$clog2(snakePkg::cellSize)-1:0] xCount;
    logic [$clog2(snakePkg::cellSize)-1:0] yCount;
    logic                                  lastCol;
    logic                                  lastRow;
    logic                                  squareDone;
    logic                                  plotting;

    // body square being drawn, tail first
    snakePkg::segIndex_t segIndex;

    // origin of the current square
    snakePkg::point_t origin;

    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            frameCount <= '0;
        end
        else
        begin
            frameCount <= frameCount + 1'b1;
        end
    end

    // one tick per counter wrap
    assign tick = (frameCount == '0);

    assign lastCol    = (xCount == snakePkg::cellSize - 1);
    assign lastRow    = (yCount == snakePkg::cellSize - 1);
    assign squareDone = lastCol && lastRow;
    assign plotting   = (state == snakePkg::drawApple) || (state == snakePkg::drawBody) ||
                        (state == snakePkg::eraseBody);

    // next state
    always_comb
    begin
        nextState = state;
        case (state)
            snakePkg::idle:
                if (go && tick)
                begin
                    nextState = snakePkg::drawApple;
                end
            snakePkg::drawApple:
                if (squareDone)
                begin
                    nextState = snakePkg::drawBody;
                end
            // head square is the last one drawn
            snakePkg::drawBody:
                if (squareDone && segIndex == '0)
                begin
                    nextState = snakePkg::waitTick;
                end
            snakePkg::waitTick:
                if (tick)
                begin
                    nextState = snakePkg::eraseBody;
                end
            snakePkg::eraseBody:
                if (squareDone && segIndex == '0)
                begin
                    nextState = snakePkg::checkHit;
                end
            // collision ends the game for good
            snakePkg::checkHit:
                nextState = hit ? snakePkg::gameOver : snakePkg::advance;
            snakePkg::advance:
                nextState = snakePkg::drawApple;
            default:
                nextState = snakePkg::gameOver;
        endcase
    end

    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            state <= snakePkg::idle;
        end
        else
        begin
            state <= nextState;
        end
    end

    // x runs fastest, rows top to bottom
    // counters rest at zero between squares
    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            xCount <= '0;
            yCount <= '0;
        end
        else if (plotting)
        begin
            if (lastCol)
            begin
                xCount <= '0;
                yCount <= lastRow ? '0 : yCount + 1'b1;
            end
            else
            begin
                xCount <= xCount + 1'b1;
            end
        end
    end

    // step down toward the head after each body square
    // wraps back to the tail after the head
    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            segIndex <= snakePkg::segIndex_t'(snakePkg::snakeLength - 1);
        end
        else if ((state == snakePkg::drawBody || state == snakePkg::eraseBody) && squareDone)
        begin
            if (segIndex == '0)
            begin
                segIndex <= snakePkg::segIndex_t'(snakePkg::snakeLength - 1);
            end
            else
            begin
                segIndex <= segIndex - 1'b1;
            end
        end
    end

    // apple square or the selected body square
    always_comb
    begin
        if (state == snakePkg::drawApple)
        begin
            origin.x = snakePkg::appleX;
            origin.y = snakePkg::appleY;
        end
        else
        begin
            origin = segments[segIndex];
        end
    end

    // frame buffer write
    always_comb
    begin
        pixel.plot = plotting;
        pixel.x    = origin.x + snakePkg::xCoord_t'(xCount);
        pixel.y    = origin.y + snakePkg::yCoord_t'(yCount);
        case (state)
            snakePkg::drawApple: pixel.colour = snakePkg::appleColour;
            snakePkg::drawBody:  pixel.colour = snakeColour;
            default:             pixel.colour = snakePkg::eraseColour;
        endcase
    end

    // body shifts one pixel at the end of each frame
    assign step     = (state == snakePkg::advance);
    assign gameOver = (state == snakePkg::gameOver);

endmodule

// ==== rtl/collisionCheck.sv ====
// collisionCheck: overlap test of the head square against the other body squares
`timescale 1ns/1ns

module collisionCheck
(
    input  snakePkg::segments_t segments,
    output logic                hit
);

    // per-segment overlap flags for the squares behind the head
    logic [snakePkg::snakeLength-1:1] overlap;

    always_comb
    begin
        snakePkg::xCoord_t dx;
        snakePkg::yCoord_t dy;
        overlap = '0;
        for (int k = 1; k < snakePkg::snakeLength; k++)
        begin
            // absolute distance between origins
            if (segments[0].x >= segments[k].x)
            begin
                dx = segments[0].x - segments[k].x;
            end
            else
            begin
                dx = segments[k].x - segments[0].x;
            end
            if (segments[0].y >= segments[k].y)
            begin
                dy = segments[0].y - segments[k].y;
            end
            else
            begin
                dy = segments[k].y - segments[0].y;
            end
            // squares share a pixel when both gaps are under one edge
            overlap[k] = (dx < snakePkg::cellSize) && (dy < snakePkg::cellSize);
        end
    end

    // any body square touched
    assign hit = |overlap;

endmodule

// ==== rtl/snakeBody.sv ====
// snakeBody: direction register, position history and segment origin taps
`timescale 1ns/1ns

module snakeBody
(
    input  logic                Clock,
    input  logic                reset,
    input  snakePkg::dirKeys_t  keys,
    input  logic                step,
    output snakePkg::segments_t segments
);

    // current heading
    snakePkg::direction_t dir;

    // head position trail, entry 0 is the newest
    snakePkg::point_t [snakePkg::historyDepth-1:0] history;

    // head after one pixel of movement
    snakePkg::point_t nextHead;

    // priority right, down, up, left
    // no key pressed keeps the last heading
    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            dir <= snakePkg::dirUp;
        end
        else if (keys.right)
        begin
            dir <= snakePkg::dirRight;
        end
        else if (keys.down)
        begin
            dir <= snakePkg::dirDown;
        end
        else if (keys.up)
        begin
            dir <= snakePkg::dirUp;
        end
        else if (keys.left)
        begin
            dir <= snakePkg::dirLeft;
        end
    end

    // coordinates wrap at their vector width
    always_comb
    begin
        nextHead = history[0];
        case (dir)
            snakePkg::dirUp:    nextHead.y = history[0].y - 7'd1;
            snakePkg::dirDown:  nextHead.y = history[0].y + 7'd1;
            snakePkg::dirLeft:  nextHead.x = history[0].x - 8'd1;
            default:            nextHead.x = history[0].x + 8'd1;
        endcase
    end

    // reset lays the snake out vertically below the head
    // a step pushes the new head in and drops the oldest entry
    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            for (int i = 0; i < snakePkg::historyDepth; i++)
            begin
                history[i].x <= snakePkg::startX;
                history[i].y <= snakePkg::startY + snakePkg::yCoord_t'(i);
            end
        end
        else if (step)
        begin
            history <= {history[snakePkg::historyDepth-2:0], nextHead};
        end
    end

    // every tenth entry starts a body square
    always_comb
    begin
        for (int k = 0; k < snakePkg::snakeLength; k++)
        begin
            segments[k] = history[k * snakePkg::cellSize];
        end
    end

endmodule

// ==== rtl/snakePkg.sv ====
// snake game constants, coordinate types, bus structs and state enums
package snakePkg;

    // frame buffer size in pixels
    localparam int screenWidth  = 160;
    localparam int screenHeight = 120;

    // square edge, body squares, history entries
    localparam int cellSize     = 10;
    localparam int snakeLength  = 6;
    localparam int historyDepth = snakeLength * cellSize;

    // 64 cycles per tick in simulation, hardware would use 20 bits
    localparam int frameTickBits = 6;

    // coordinate and colour widths
    typedef logic [7:0] xCoord_t;
    typedef logic [6:0] yCoord_t;
    typedef logic [2:0] colour_t;
    typedef logic [2:0] segIndex_t;

    // head origin after reset and the fixed apple
    localparam xCoord_t startX = 8'd80;
    localparam yCoord_t startY = 7'd60;
    localparam xCoord_t appleX = 8'd30;
    localparam yCoord_t appleY = 7'd30;

    // red apple, black erase
    localparam colour_t appleColour = 3'b100;
    localparam colour_t eraseColour = 3'b000;

    typedef struct packed {
        xCoord_t x;
        yCoord_t y;
    } point_t;

    // segment origins, head at index 0
    typedef point_t [snakeLength-1:0] segments_t;

    // button levels, active high
    typedef struct packed {
        logic right;
        logic down;
        logic up;
        logic left;
    } dirKeys_t;

    typedef enum logic [1:0] {dirUp, dirDown, dirLeft, dirRight} direction_t;

    // one frame buffer write, valid while plot is high
    typedef struct packed {
        logic    plot;
        xCoord_t x;
        yCoord_t y;
        colour_t colour;
    } pixelOut_t;

    typedef enum logic [2:0] {
        idle, drawApple, drawBody, waitTick, eraseBody, checkHit, advance, gameOver
    } drawState_t;

endpackage
